// File: hdl/skdecode_settings.svh
// Scheme dimensions and memory sizes for the key decoder; include wherever a width is needed
`ifndef SKDECODE_SETTINGS_SVH
`define SKDECODE_SETTINGS_SVH

// ML-DSA scheme dimensions
`define SKD_L 7
`define SKD_K 8
`define SKD_N 256
`define SKD_ETA 2
`define SKD_Q 8380417

// Memory geometry
`define SKD_MEM_ADDR_W 15
`define SKD_KMEM_ADDR_W 14
`define SKD_KMEM_DATA_W 32
`define SKD_COEFF_W 24
// Four coefficients per polynomial word
`define SKD_MEM_DATA_W 96

`endif

// File: hdl/mem_types_pkg.sv
// Memory request types shared by every block that drives the key or polynomial memory
`default_nettype none

`include "skdecode_settings.svh"

package mem_types_pkg;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } mem_rw_mode_e;

    // Polynomial memory port request
    typedef struct packed {
        mem_rw_mode_e                rd_wr_en;
        logic [`SKD_MEM_ADDR_W-1:0]  addr;
    } mem_req_t;

    // Key memory port request
    typedef struct packed {
        mem_rw_mode_e                rd_wr_en;
        logic [`SKD_KMEM_ADDR_W-1:0] addr;
    } kmem_req_t;

endpackage

`default_nettype wire

// File: hdl/skdecode_pkg.sv
// State encodings and coefficient arithmetic for the key decoder, imported by its blocks
`default_nettype none

`include "skdecode_settings.svh"

package skdecode_pkg;

    typedef logic [`SKD_COEFF_W-1:0] coeff_t;

    typedef enum logic [2:0] {
        SKDEC_RD_IDLE, SKDEC_RD_S1, SKDEC_RD_S2, SKDEC_RD_T0, SKDEC_RD_STAGE
    } skdec_rd_state_e;

    typedef enum logic [2:0] {
        SKDEC_WR_IDLE, SKDEC_WR_S1, SKDEC_WR_S2, SKDEC_WR_T0, SKDEC_WR_STAGE
    } skdec_wr_state_e;

    // Constant minus field, folded into [0, q)
    function automatic coeff_t sub_mod_q(input logic [12:0] c, input logic [12:0] f);
        if (f > c) begin
            return coeff_t'(`SKD_Q) - coeff_t'(f - c);
        end else begin
            return coeff_t'(c - f);
        end
    endfunction

endpackage

`default_nettype wire

// File: hdl/skdecode_if.sv
// Control and status strobes between the decoder controller and the s1/s2 unpacker
`timescale 1ns/100ps
`default_nettype none

interface skdecode_if;

    // Key word present this cycle
    logic enable;
    // Fourth phase of a group, drain only
    logic buf_stall;
    // One strobe per written word pair
    logic valid;
    // Bad field seen in that word pair
    logic error;

    modport ctrl (output enable, output buf_stall, input valid, input error);

    modport unpack (input enable, input buf_stall, output valid, output error);

endinterface

`default_nettype wire

// File: hdl/skdecode_ctrl.sv
// Read and write state machines of the key decoder; drives both memories and the unpackers
`timescale 1ns/100ps
`default_nettype none

`include "skdecode_settings.svh"

module skdecode_ctrl (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          zeroize,
    input  wire                          skdecode_enable,
    input  wire [`SKD_KMEM_ADDR_W-1:0]   src_base_addr,
    input  wire [`SKD_MEM_ADDR_W-1:0]    dest_base_addr,
    skdecode_if.ctrl                     s1s2,
    input  wire                          t0_valid,
    input  wire                          t0_buf_stall,
    output logic                         t0_enable,
    output mem_types_pkg::mem_req_t      mem_a_wr_req,
    output mem_types_pkg::mem_req_t      mem_b_wr_req,
    output mem_types_pkg::kmem_req_t     kmem_a_rd_req,
    output mem_types_pkg::kmem_req_t     kmem_b_rd_req,
    output logic                         skdecode_done,
    output logic                         skdecode_error
);
    import mem_types_pkg::*;
    import skdecode_pkg::*;

    // Polynomials x N / coefficients per cycle
    localparam logic [8:0] S1_LAST = 9'(`SKD_L * `SKD_N / 8 - 1);
    localparam logic [8:0] S2_LAST = 9'(`SKD_K * `SKD_N / 8 - 1);
    // t0 counts issued reads, 64 key bits each
    localparam logic [8:0] T0_LAST = 9'(`SKD_K * `SKD_N * 13 / 64 - 1);

    // Destination word where each segment ends
    localparam logic [`SKD_MEM_ADDR_W-1:0] S1_END = `SKD_MEM_ADDR_W'(64 * `SKD_L);
    localparam logic [`SKD_MEM_ADDR_W-1:0] S2_END = `SKD_MEM_ADDR_W'(64 * (`SKD_L + `SKD_K));
    localparam logic [`SKD_MEM_ADDR_W-1:0] T0_END =
        `SKD_MEM_ADDR_W'(64 * (`SKD_L + 2 * `SKD_K));

    skdec_rd_state_e rd_state, rd_state_nxt;
    skdec_wr_state_e wr_state, wr_state_nxt;
    skdec_wr_state_e seg_done;

    logic [8:0]                  rd_count;
    logic [8:0]                  rd_last;
    logic [1:0]                  stall_count;
    logic [`SKD_KMEM_ADDR_W-1:0] kmem_rd_addr;
    logic [`SKD_MEM_ADDR_W-1:0]  wr_word;
    logic [`SKD_MEM_ADDR_W-1:0]  wr_end;
    logic s1s2_rd, t0_rd, rd_issue, phase_stall, rd_seg_last;
    logic start, both_staged, s1s2_wr, wr_valid, wr_seg_full;

    always_comb begin
        s1s2_rd     = (rd_state == SKDEC_RD_S1) || (rd_state == SKDEC_RD_S2);
        phase_stall = s1s2_rd && (stall_count == 2'd3);
        t0_rd       = (rd_state == SKDEC_RD_T0) && !t0_buf_stall;
        rd_issue    = (s1s2_rd && !phase_stall) || t0_rd;
        case (rd_state)
            SKDEC_RD_S1: rd_last = S1_LAST;
            SKDEC_RD_S2: rd_last = S2_LAST;
            default:     rd_last = T0_LAST;
        endcase
        rd_seg_last = (s1s2_rd || t0_rd) && (rd_count == rd_last);

        s1s2_wr  = (wr_state == SKDEC_WR_S1) || (wr_state == SKDEC_WR_S2);
        wr_valid = (s1s2_wr && s1s2.valid) || ((wr_state == SKDEC_WR_T0) && t0_valid);
        case (wr_state)
            SKDEC_WR_S1: wr_end = S1_END;
            SKDEC_WR_S2: wr_end = S2_END;
            default:     wr_end = T0_END;
        endcase
        // Segment closes once reads are staged and the last word is in
        wr_seg_full = (wr_word == wr_end) && !wr_valid && (rd_state == SKDEC_RD_STAGE);

        start       = skdecode_enable && (wr_state == SKDEC_WR_IDLE);
        both_staged = (rd_state == SKDEC_RD_STAGE) && (wr_state == SKDEC_WR_STAGE);
    end

    // ------------------------------------------------------------------
    // Read machine
    // ------------------------------------------------------------------
    always_comb begin
        rd_state_nxt = rd_state;
        unique case (rd_state)
            SKDEC_RD_IDLE: begin
                if (start) rd_state_nxt = SKDEC_RD_S1;
            end
            SKDEC_RD_S1, SKDEC_RD_S2, SKDEC_RD_T0: begin
                if (rd_seg_last) rd_state_nxt = SKDEC_RD_STAGE;
            end
            default: begin
                if (both_staged) begin
                    rd_state_nxt = (seg_done == SKDEC_WR_S1) ? SKDEC_RD_S2 :
                                   (seg_done == SKDEC_WR_S2) ? SKDEC_RD_T0 : SKDEC_RD_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state     <= SKDEC_RD_IDLE;
            rd_count     <= '0;
            stall_count  <= '0;
            kmem_rd_addr <= '0;
        end else if (zeroize) begin
            rd_state     <= SKDEC_RD_IDLE;
            rd_count     <= '0;
            stall_count  <= '0;
            kmem_rd_addr <= '0;
        end else begin
            rd_state <= rd_state_nxt;
            if (s1s2_rd || t0_rd) begin
                rd_count <= rd_seg_last ? 9'd0 : rd_count + 9'd1;
            end
            // Four-phase group, three reads and one drain
            stall_count <= s1s2_rd ? stall_count + 2'd1 : 2'd0;
            if (rd_state == SKDEC_RD_IDLE) begin
                kmem_rd_addr <= '0;
            end else if (rd_issue) begin
                kmem_rd_addr <= kmem_rd_addr + (t0_rd ? `SKD_KMEM_ADDR_W'(2) :
                                                        `SKD_KMEM_ADDR_W'(1));
            end
        end
    end

    // ------------------------------------------------------------------
    // Write machine
    // ------------------------------------------------------------------
    always_comb begin
        wr_state_nxt = wr_state;
        unique case (wr_state)
            SKDEC_WR_IDLE: begin
                if (start) wr_state_nxt = SKDEC_WR_S1;
            end
            SKDEC_WR_S1, SKDEC_WR_S2, SKDEC_WR_T0: begin
                if (wr_seg_full) wr_state_nxt = SKDEC_WR_STAGE;
            end
            default: begin
                if (both_staged) begin
                    wr_state_nxt = (seg_done == SKDEC_WR_S1) ? SKDEC_WR_S2 :
                                   (seg_done == SKDEC_WR_S2) ? SKDEC_WR_T0 : SKDEC_WR_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state       <= SKDEC_WR_IDLE;
            seg_done       <= SKDEC_WR_IDLE;
            wr_word        <= '0;
            skdecode_error <= 1'b0;
            s1s2.enable    <= 1'b0;
            s1s2.buf_stall <= 1'b0;
            t0_enable      <= 1'b0;
        end else if (zeroize) begin
            wr_state       <= SKDEC_WR_IDLE;
            seg_done       <= SKDEC_WR_IDLE;
            wr_word        <= '0;
            skdecode_error <= 1'b0;
            s1s2.enable    <= 1'b0;
            s1s2.buf_stall <= 1'b0;
            t0_enable      <= 1'b0;
        end else begin
            wr_state <= wr_state_nxt;
            if (wr_seg_full) seg_done <= wr_state;
            // Running word index, s1/s2 write a pair per valid
            if (wr_state == SKDEC_WR_IDLE) begin
                wr_word <= '0;
            end else if (wr_valid) begin
                wr_word <= wr_word + (s1s2_wr ? `SKD_MEM_ADDR_W'(2) : `SKD_MEM_ADDR_W'(1));
            end
            if (start) begin
                skdecode_error <= 1'b0;
            end else if (s1s2_wr && s1s2.valid && s1s2.error) begin
                skdecode_error <= 1'b1;
            end
            // Aligned with key data one cycle after the read
            s1s2.enable    <= s1s2_rd && !phase_stall;
            s1s2.buf_stall <= phase_stall;
            t0_enable      <= t0_rd;
        end
    end

    always_comb begin
        mem_a_wr_req.rd_wr_en  = wr_valid ? RW_WRITE : RW_IDLE;
        mem_a_wr_req.addr      = dest_base_addr + wr_word;
        // Port b only carries the odd word of an s1/s2 pair
        mem_b_wr_req.rd_wr_en  = (wr_valid && s1s2_wr) ? RW_WRITE : RW_IDLE;
        mem_b_wr_req.addr      = dest_base_addr + wr_word + `SKD_MEM_ADDR_W'(1);
        kmem_a_rd_req.rd_wr_en = rd_issue ? RW_READ : RW_IDLE;
        kmem_a_rd_req.addr     = src_base_addr + kmem_rd_addr;
        kmem_b_rd_req.rd_wr_en = t0_rd ? RW_READ : RW_IDLE;
        kmem_b_rd_req.addr     = src_base_addr + kmem_rd_addr + `SKD_KMEM_ADDR_W'(1);
        skdecode_done          = (wr_state == SKDEC_WR_IDLE);
    end

endmodule

`default_nettype wire

// File: hdl/s1s2_unpack.sv
// Unpacks 3-bit s1/s2 fields from key words into eight coefficients per valid strobe
`timescale 1ns/100ps
`default_nettype none

`include "skdecode_settings.svh"

module s1s2_unpack (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          zeroize,
    skdecode_if.unpack                   ctl,
    input  wire [`SKD_KMEM_DATA_W-1:0]   kmem_rd_data,
    output logic [`SKD_MEM_DATA_W-1:0]   wr_data_a,
    output logic [`SKD_MEM_DATA_W-1:0]   wr_data_b
);
    import skdecode_pkg::*;

    logic [63:0]                  bit_buf;
    logic [63:0]                  merged;
    logic [5:0]                   fill;
    logic [8*`SKD_COEFF_W-1:0]    coeffs;
    logic                         emit;
    logic                         bad;

    assign emit = ctl.enable | ctl.buf_stall;

    always_comb begin
        merged = bit_buf;
        // New word lands above the bits still held
        if (ctl.enable) begin
            merged = bit_buf | (64'(kmem_rd_data) << fill);
        end
        bad = 1'b0;
        for (int i = 0; i < 8; i++) begin
            coeffs[i*`SKD_COEFF_W +: `SKD_COEFF_W] =
                sub_mod_q(13'(`SKD_ETA), 13'(merged[i*3 +: 3]));
            bad = bad | (merged[i*3 +: 3] > 3'(2 * `SKD_ETA));
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_buf   <= '0;
            fill      <= '0;
            ctl.valid <= 1'b0;
            ctl.error <= 1'b0;
        end else if (zeroize) begin
            bit_buf   <= '0;
            fill      <= '0;
            ctl.valid <= 1'b0;
            ctl.error <= 1'b0;
        end else begin
            if (emit) begin
                bit_buf <= merged >> 24;
                fill    <= ctl.enable ? fill + 6'd8 : fill - 6'd24;
            end
            ctl.valid <= emit;
            ctl.error <= emit & bad;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            wr_data_a <= coeffs[`SKD_MEM_DATA_W-1:0];
            wr_data_b <= coeffs[2*`SKD_MEM_DATA_W-1:`SKD_MEM_DATA_W];
        end
    end

endmodule

`default_nettype wire

// File: hdl/t0_unpack.sv
// Unpacks 13-bit t0 fields from key word pairs into four coefficients per valid strobe
`timescale 1ns/100ps
`default_nettype none

`include "skdecode_settings.svh"

module t0_unpack (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          zeroize,
    input  wire                          t0_enable,
    input  wire [`SKD_KMEM_DATA_W-1:0]   kmem_a_rd_data,
    input  wire [`SKD_KMEM_DATA_W-1:0]   kmem_b_rd_data,
    output logic                         t0_valid,
    output logic                         t0_buf_stall,
    output logic [`SKD_MEM_DATA_W-1:0]   wr_data
);
    import skdecode_pkg::*;

    logic [127:0]                 bit_buf;
    logic [127:0]                 merged;
    logic [7:0]                   fill;
    logic [7:0]                   fill_in;
    logic [`SKD_MEM_DATA_W-1:0]   coeffs;
    logic                         emit;

    // A read in flight may add 12 net bits before the next one lands
    assign t0_buf_stall = (fill > 8'd52);

    always_comb begin
        merged  = bit_buf;
        fill_in = fill;
        if (t0_enable) begin
            merged  = bit_buf | (128'({kmem_b_rd_data, kmem_a_rd_data}) << fill);
            fill_in = fill + 8'd64;
        end
        emit = (fill_in >= 8'd52);
        for (int i = 0; i < 4; i++) begin
            coeffs[i*`SKD_COEFF_W +: `SKD_COEFF_W] = sub_mod_q(13'd4096, merged[i*13 +: 13]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_buf  <= '0;
            fill     <= '0;
            t0_valid <= 1'b0;
        end else if (zeroize) begin
            bit_buf  <= '0;
            fill     <= '0;
            t0_valid <= 1'b0;
        end else begin
            // Enabled cycles always reach 52 bits, so no separate append path
            if (emit) begin
                bit_buf <= merged >> 52;
                fill    <= fill_in - 8'd52;
            end
            t0_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) wr_data <= coeffs;
    end

endmodule

`default_nettype wire

// File: hdl/skdecode_top.sv
// Top of the secret-key decoder; instantiate with plain key and polynomial memory ports
`timescale 1ns/100ps
`default_nettype none

`include "skdecode_settings.svh"

module skdecode_top (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          zeroize,
    input  wire                          skdecode_enable,
    input  wire [`SKD_KMEM_ADDR_W-1:0]   src_base_addr,
    input  wire [`SKD_MEM_ADDR_W-1:0]    dest_base_addr,
    input  wire [`SKD_KMEM_DATA_W-1:0]   kmem_a_rd_data,
    input  wire [`SKD_KMEM_DATA_W-1:0]   kmem_b_rd_data,
    output logic                         kmem_a_rd_en,
    output logic [`SKD_KMEM_ADDR_W-1:0]  kmem_a_rd_addr,
    output logic                         kmem_b_rd_en,
    output logic [`SKD_KMEM_ADDR_W-1:0]  kmem_b_rd_addr,
    output logic                         mem_a_wr_en,
    output logic [`SKD_MEM_ADDR_W-1:0]   mem_a_wr_addr,
    output logic [`SKD_MEM_DATA_W-1:0]   mem_a_wr_data,
    output logic                         mem_b_wr_en,
    output logic [`SKD_MEM_ADDR_W-1:0]   mem_b_wr_addr,
    output logic [`SKD_MEM_DATA_W-1:0]   mem_b_wr_data,
    output logic                         skdecode_done,
    output logic                         skdecode_error
);
    import mem_types_pkg::*;

    mem_req_t                   mem_a_wr_req, mem_b_wr_req;
    kmem_req_t                  kmem_a_rd_req, kmem_b_rd_req;
    logic                       t0_enable, t0_valid, t0_buf_stall;
    logic [`SKD_MEM_DATA_W-1:0] s1s2_data_a, s1s2_data_b, t0_data;

    skdecode_if s1s2_if ();

    skdecode_ctrl skdecode_ctrl_i (
        .clk, .reset_n, .zeroize, .skdecode_enable, .src_base_addr, .dest_base_addr,
        .s1s2 (s1s2_if.ctrl),
        .t0_valid, .t0_buf_stall, .t0_enable,
        .mem_a_wr_req, .mem_b_wr_req, .kmem_a_rd_req, .kmem_b_rd_req,
        .skdecode_done, .skdecode_error
    );

    s1s2_unpack s1s2_unpack_i (
        .clk, .reset_n, .zeroize,
        .ctl          (s1s2_if.unpack),
        .kmem_rd_data (kmem_a_rd_data),
        .wr_data_a    (s1s2_data_a),
        .wr_data_b    (s1s2_data_b)
    );

    t0_unpack t0_unpack_i (
        .clk, .reset_n, .zeroize, .t0_enable, .kmem_a_rd_data, .kmem_b_rd_data,
        .t0_valid, .t0_buf_stall,
        .wr_data (t0_data)
    );

    // Flatten requests to plain memory ports
    always_comb begin
        kmem_a_rd_en   = (kmem_a_rd_req.rd_wr_en == RW_READ);
        kmem_a_rd_addr = kmem_a_rd_req.addr;
        kmem_b_rd_en   = (kmem_b_rd_req.rd_wr_en == RW_READ);
        kmem_b_rd_addr = kmem_b_rd_req.addr;
        mem_a_wr_en    = (mem_a_wr_req.rd_wr_en == RW_WRITE);
        mem_a_wr_addr  = mem_a_wr_req.addr;
        // Only one unpacker strobes valid at a time
        mem_a_wr_data  = t0_valid ? t0_data : s1s2_data_a;
        mem_b_wr_en    = (mem_b_wr_req.rd_wr_en == RW_WRITE);
        mem_b_wr_addr  = mem_b_wr_req.addr;
        mem_b_wr_data  = s1s2_data_b;
    end

endmodule

`default_nettype wire

// File: verification/skdecode_assertions.sv
// Concurrent protocol checks on the decoder top-level ports, attached to skdecode_top by bind
`timescale 1ns/100ps
`default_nettype none

`include "skdecode_settings.svh"

module skdecode_assertions (
    input wire                          clk,
    input wire                          reset_n,
    input wire                          zeroize,
    input wire                          skdecode_enable,
    input wire [`SKD_KMEM_ADDR_W-1:0]   src_base_addr,
    input wire [`SKD_MEM_ADDR_W-1:0]    dest_base_addr,
    input wire                          kmem_a_rd_en,
    input wire [`SKD_KMEM_ADDR_W-1:0]   kmem_a_rd_addr,
    input wire                          kmem_b_rd_en,
    input wire [`SKD_KMEM_ADDR_W-1:0]   kmem_b_rd_addr,
    input wire                          mem_a_wr_en,
    input wire [`SKD_MEM_ADDR_W-1:0]    mem_a_wr_addr,
    input wire                          mem_b_wr_en,
    input wire [`SKD_MEM_ADDR_W-1:0]    mem_b_wr_addr,
    input wire                          skdecode_done,
    input wire                          skdecode_error,
    input wire                          t0_valid
);

    // Key words for s1, s2 and t0, and destination words for all three
    localparam logic [`SKD_KMEM_ADDR_W-1:0] KEY_SPAN =
        `SKD_KMEM_ADDR_W'(24 * `SKD_L + 128 * `SKD_K);
    localparam logic [`SKD_MEM_ADDR_W-1:0] DEST_SPAN =
        `SKD_MEM_ADDR_W'(64 * (`SKD_L + 2 * `SKD_K));

    int   fail_count = 0;
    logic any_req;

    assign any_req = kmem_a_rd_en | kmem_b_rd_en | mem_a_wr_en | mem_b_wr_en;

    // ------------------------------------------------------------------
    // Reset, zeroize and idle behavior
    // ------------------------------------------------------------------
    assert property (@(posedge clk) $rose(reset_n) |->
                     skdecode_done && !skdecode_error && !any_req)
        else begin $error("Outputs not idle after reset"); fail_count++; end

    assert property (@(posedge clk) disable iff (!reset_n) skdecode_done |-> !any_req)
        else begin $error("Memory request while done is high"); fail_count++; end

    assert property (@(posedge clk) disable iff (!reset_n) zeroize |=>
                     skdecode_done && !any_req)
        else begin $error("Decoder still active after zeroize"); fail_count++; end

    // Sticky error until the next start
    assert property (@(posedge clk) disable iff (!reset_n)
                     skdecode_error && !skdecode_enable && !zeroize |=> skdecode_error)
        else begin $error("Error flag dropped before the next start"); fail_count++; end

    // ------------------------------------------------------------------
    // Address ranges and port use
    // ------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!reset_n)
                     mem_a_wr_en |-> (mem_a_wr_addr - dest_base_addr) < DEST_SPAN)
        else begin $error("Port a write outside the destination"); fail_count++; end

    assert property (@(posedge clk) disable iff (!reset_n)
                     mem_b_wr_en |-> (mem_b_wr_addr - dest_base_addr) < DEST_SPAN)
        else begin $error("Port b write outside the destination"); fail_count++; end

    assert property (@(posedge clk) disable iff (!reset_n)
                     kmem_a_rd_en |-> (kmem_a_rd_addr - src_base_addr) < KEY_SPAN)
        else begin $error("Port a key read outside the key"); fail_count++; end

    assert property (@(posedge clk) disable iff (!reset_n)
                     kmem_b_rd_en |-> (kmem_b_rd_addr - src_base_addr) < KEY_SPAN)
        else begin $error("Port b key read outside the key"); fail_count++; end

    assert property (@(posedge clk) disable iff (!reset_n) t0_valid |-> !mem_b_wr_en)
        else begin $error("Port b written during t0"); fail_count++; end

endmodule

bind skdecode_top skdecode_assertions skdecode_assertions_i (.*);

`default_nettype wire

// File: verification/skdecode_tb.sv
// Testbench for the key decoder; models both memories and runs clean, faulty and zeroized decodes
`timescale 1ns/100ps
`default_nettype none

`include "skdecode_settings.svh"

module skdecode_tb;

    localparam int S1S2_WORDS  = 24 * (`SKD_L + `SKD_K);
    localparam int T0_WORDS    = 104 * `SKD_K;
    localparam int S1S2_FIELDS = (`SKD_L + `SKD_K) * `SKD_N;
    localparam int S1S2_DEST   = 64 * (`SKD_L + `SKD_K);
    localparam int DEST_WORDS  = 64 * (`SKD_L + 2 * `SKD_K);
    localparam int TIMEOUT     = 5000;
    localparam logic [`SKD_KMEM_ADDR_W-1:0] SRC_BASE  = `SKD_KMEM_ADDR_W'('h123);
    localparam logic [`SKD_MEM_ADDR_W-1:0]  DEST_BASE = `SKD_MEM_ADDR_W'('h456);

    logic                         clk;
    logic                         reset_n;
    logic                         zeroize;
    logic                         skdecode_enable;
    logic [`SKD_KMEM_ADDR_W-1:0]  src_base_addr;
    logic [`SKD_MEM_ADDR_W-1:0]   dest_base_addr;
    logic [`SKD_KMEM_DATA_W-1:0]  kmem_a_rd_data = '0;
    logic [`SKD_KMEM_DATA_W-1:0]  kmem_b_rd_data = '0;
    logic                         kmem_a_rd_en, kmem_b_rd_en;
    logic [`SKD_KMEM_ADDR_W-1:0]  kmem_a_rd_addr, kmem_b_rd_addr;
    logic                         mem_a_wr_en, mem_b_wr_en;
    logic [`SKD_MEM_ADDR_W-1:0]   mem_a_wr_addr, mem_b_wr_addr;
    logic [`SKD_MEM_DATA_W-1:0]   mem_a_wr_data, mem_b_wr_data;
    logic                         skdecode_done;
    logic                         skdecode_error;

    logic [`SKD_KMEM_DATA_W-1:0]  kmem [0:(1 << `SKD_KMEM_ADDR_W)-1];
    logic [`SKD_MEM_DATA_W-1:0]   dmem [0:(1 << `SKD_MEM_ADDR_W)-1];
    logic                         a_pend, b_pend;
    logic [`SKD_KMEM_ADDR_W-1:0]  a_pend_addr, b_pend_addr;
    integer                       seed;
    int                           data_errors;
    int                           status_errors;
    logic                         timed_out;

    skdecode_top skdecode_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------
    // Key read data one cycle after the request, polynomial writes captured mid-cycle
    always @(negedge clk) begin
        if (a_pend) kmem_a_rd_data = kmem[a_pend_addr];
        if (b_pend) kmem_b_rd_data = kmem[b_pend_addr];
        a_pend      = kmem_a_rd_en;
        a_pend_addr = kmem_a_rd_addr;
        b_pend      = kmem_b_rd_en;
        b_pend_addr = kmem_b_rd_addr;
        if (mem_a_wr_en) dmem[mem_a_wr_addr] = mem_a_wr_data;
        if (mem_b_wr_en) dmem[mem_b_wr_addr] = mem_b_wr_data;
    end

    // Key word holding bit p of a segment that starts at word first
    function automatic logic [`SKD_KMEM_ADDR_W-1:0] key_word(input int first, input int p);
        return `SKD_KMEM_ADDR_W'(int'(SRC_BASE) + first + p / 32);
    endfunction

    task automatic put_field(input int first, input int k, input int width, input int value);
        int p;
        for (int b = 0; b < width; b++) begin
            p = k * width + b;
            kmem[key_word(first, p)][p % 32] = 1'(value >> b);
        end
    endtask

    function automatic int get_field(input int first, input int k, input int width);
        int p;
        int v;
        v = 0;
        for (int b = 0; b < width; b++) begin
            p = k * width + b;
            v = v | (int'(kmem[key_word(first, p)][p % 32]) << b);
        end
        return v;
    endfunction

    task automatic load_key(input int bad_field);
        for (int i = 0; i < S1S2_WORDS + T0_WORDS; i++) begin
            kmem[key_word(0, 32 * i)] = $random(seed);
        end
        // s1 and s2 form one stream of fields in 0 to 2*eta
        for (int k = 0; k < S1S2_FIELDS; k++) begin
            put_field(0, k, 3, int'({$random(seed)} % (2 * `SKD_ETA + 1)));
        end
        if (bad_field >= 0) put_field(0, bad_field, 3, 7);
    endtask

    // Four coefficients of destination word w, lowest index in the low bits
    function automatic logic [`SKD_MEM_DATA_W-1:0] expected_word(input int w);
        logic [`SKD_MEM_DATA_W-1:0] e;
        int f;
        for (int m = 0; m < 4; m++) begin
            if (w < S1S2_DEST) begin
                f = get_field(0, 4 * w + m, 3);
                e[m*`SKD_COEFF_W +: `SKD_COEFF_W] =
                    `SKD_COEFF_W'((`SKD_Q + `SKD_ETA - f) % `SKD_Q);
            end else begin
                f = get_field(S1S2_WORDS, 4 * (w - S1S2_DEST) + m, 13);
                e[m*`SKD_COEFF_W +: `SKD_COEFF_W] =
                    `SKD_COEFF_W'((`SKD_Q + (1 << 12) - f) % `SKD_Q);
            end
        end
        return e;
    endfunction

    // ------------------------------------------------------------------
    // Checks and run control
    // ------------------------------------------------------------------
    task automatic check_memory();
        logic [`SKD_MEM_DATA_W-1:0] exp;
        logic [`SKD_MEM_ADDR_W-1:0] a;
        for (int w = 0; w < DEST_WORDS; w++) begin
            exp = expected_word(w);
            a = DEST_BASE + `SKD_MEM_ADDR_W'(w);
            if (dmem[a] !== exp) begin
                $display("FAIL mem_wr_data[%h]: got %h expected %h", a, dmem[a], exp);
                data_errors++;
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            status_errors++;
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = skdecode_top_i.skdecode_assertions_i.fail_count;
        $display("Errors: %0d data, %0d status, %0d assertion",
                 data_errors, status_errors, assert_errors);
        if (data_errors + status_errors + assert_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!skdecode_done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!skdecode_done) begin
            $display("Timeout: decoder did not raise done within %0d cycles", TIMEOUT);
            status_errors++;
            timed_out = 1'b1;
        end
    endtask

    // zeroize_at of 0 lets the decode run to completion and checks the memory
    task automatic decode_run(input int bad_field, input int zeroize_at, input logic exp_error);
        if (!timed_out) begin
            load_key(bad_field);
            @(negedge clk);
            skdecode_enable = 1'b1;
            @(negedge clk);
            skdecode_enable = 1'b0;
            check_bit("skdecode_done", skdecode_done, 1'b0);
            if (zeroize_at > 0) begin
                repeat (zeroize_at) @(negedge clk);
                zeroize = 1'b1;
                @(negedge clk);
                zeroize = 1'b0;
            end
            wait_done();
            if (!timed_out) begin
                if (zeroize_at == 0) check_memory();
                check_bit("skdecode_error", skdecode_error, exp_error);
            end
        end
    endtask

    initial begin
        seed            = 53055;
        data_errors     = 0;
        status_errors   = 0;
        timed_out       = 1'b0;
        reset_n         = 1'b0;
        zeroize         = 1'b0;
        skdecode_enable = 1'b0;
        src_base_addr   = SRC_BASE;
        dest_base_addr  = DEST_BASE;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        decode_run(-1, 0, 1'b0);
        // One s1 field out of range
        decode_run(37, 0, 1'b1);
        decode_run(-1, 0, 1'b0);
        // Abort while t0 is being unpacked
        decode_run(-1, 700, 1'b0);
        finish_run();
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/skdecode_pkg.sv
hdl/skdecode_if.sv
hdl/skdecode_ctrl.sv
hdl/s1s2_unpack.sv
hdl/t0_unpack.sv
hdl/skdecode_top.sv
verification/skdecode_assertions.sv
verification/skdecode_tb.sv

// File: Makefile
TOP := skdecode_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

# Pass or fail comes from the log, not the exit status of the model
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^Done: no errors$$" sim.log

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
